/* source/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // ****************************************
    // Sizes
    // ****************************************

    // Operations renamed together on one clock edge.
    localparam int RENAME_WIDTH = 4;

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Physical registers that are not mapped at reset start out free.
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    // ****************************************
    // Index types
    // ****************************************

    typedef logic [$clog2(ARCH_REGS)-1:0] areg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] preg_t;

    // Selects one lane of a group.
    typedef logic [$clog2(RENAME_WIDTH)-1:0] lane_idx_t;

    // Counts lanes from zero up to a full group, so one bit wider than an index.
    typedef logic [$clog2(RENAME_WIDTH+1)-1:0] lane_cnt_t;

    // Occupancy of the free list, empty through completely full.
    typedef logic [$clog2(FREE_REGS+1)-1:0] free_cnt_t;

endpackage

`default_nettype wire

/* source/rename_table.sv */
`default_nettype none

module rename_table (
    input  wire logic              clk,
    input  wire logic              rst,

    // Group read ports, one set per lane.
    input  wire rename_pkg::areg_t rd_rs1 [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t rd_rs2 [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t rd_rd  [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      map_rs1 [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      map_rs2 [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      map_rd  [rename_pkg::RENAME_WIDTH],

    // Write ports, one per lane.
    input  wire logic              wr_en   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t wr_areg [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t wr_preg [rename_pkg::RENAME_WIDTH]
);

    import rename_pkg::*;

    // Current speculative mapping of every architectural register.
    preg_t map_q [ARCH_REGS];

    // ****************************************
    // Read side
    // ****************************************

    // Reads see the table as it stood before this edge. Forwarding of
    // registers renamed in the same group is handled by the stage.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            map_rs1[i] = map_q[rd_rs1[i]];
            map_rs2[i] = map_q[rd_rs2[i]];
            map_rd[i]  = map_q[rd_rd[i]];
        end
    end

    // ****************************************
    // Write side
    // ****************************************

    // Lanes are applied in ascending order, so when two enabled lanes hit the
    // same architectural register the higher lane wins.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Register a starts out in physical register a.
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= preg_t'(a);
            end
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (wr_en[i]) begin
                    map_q[wr_areg[i]] <= wr_preg[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/free_list.sv */
`default_nettype none

module free_list (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Allocation side.
    input  wire rename_pkg::lane_cnt_t alloc_num,
    input  wire logic                  alloc_take,
    output rename_pkg::preg_t          alloc_preg [rename_pkg::RENAME_WIDTH],
    output logic                       full,

    // Release side, fed by committed operations.
    input  wire logic                  commit_valid   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t     commit_old_prd [rename_pkg::RENAME_WIDTH]
);

    import rename_pkg::*;

    typedef logic [$clog2(FREE_REGS)-1:0] ptr_t;

    preg_t     fifo_q [FREE_REGS];
    ptr_t      head_q;
    ptr_t      tail_q;
    free_cnt_t count_q;

    ptr_t      rel_pos [RENAME_WIDTH];
    lane_cnt_t rel_num;
    lane_cnt_t take_num;

    // ****************************************
    // Allocation
    // ****************************************

    // The first entries at the head are offered every cycle. The pointer is
    // exactly as wide as the buffer, so the sum wraps on its own.
    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            alloc_preg[k] = fifo_q[head_q + ptr_t'(k)];
        end
    end

    assign take_num = alloc_take ? alloc_num : '0;

    // Not enough free registers for every writing lane of the current group.
    assign full = count_q < free_cnt_t'(alloc_num);

    // ****************************************
    // Release
    // ****************************************

    // Each valid commit lane takes the next tail slot after the valid lanes
    // below it, which keeps the releases in lane order.
    always_comb begin
        rel_num = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rel_pos[i] = tail_q + ptr_t'(rel_num);
            if (commit_valid[i]) begin
                rel_num = rel_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= free_cnt_t'(FREE_REGS);
            // Physical registers above the identity map, in ascending order.
            for (int e = 0; e < FREE_REGS; e++) begin
                fifo_q[e] <= preg_t'(ARCH_REGS + e);
            end
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (commit_valid[i]) begin
                    fifo_q[rel_pos[i]] <= commit_old_prd[i];
                end
            end
            head_q  <= head_q + ptr_t'(take_num);
            tail_q  <= tail_q + ptr_t'(rel_num);
            count_q <= count_q + free_cnt_t'(rel_num) - free_cnt_t'(take_num);
        end
    end

endmodule

`default_nettype wire

/* source/rename_stage.sv */
`default_nettype none

module rename_stage (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Decoded group.
    input  wire logic                  in_valid [rename_pkg::RENAME_WIDTH],
    input  wire logic                  in_we    [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t     in_rs1   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t     in_rs2   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t     in_rd    [rename_pkg::RENAME_WIDTH],
    input  wire logic                  stall,
    input  wire logic                  full,

    // Rename table.
    output rename_pkg::areg_t          rd_rs1  [rename_pkg::RENAME_WIDTH],
    output rename_pkg::areg_t          rd_rs2  [rename_pkg::RENAME_WIDTH],
    output rename_pkg::areg_t          rd_rd   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t     map_rs1 [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t     map_rs2 [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t     map_rd  [rename_pkg::RENAME_WIDTH],
    output logic                       wr_en   [rename_pkg::RENAME_WIDTH],
    output rename_pkg::areg_t          wr_areg [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t          wr_preg [rename_pkg::RENAME_WIDTH],

    // Free list.
    input  wire rename_pkg::preg_t     alloc_preg [rename_pkg::RENAME_WIDTH],
    output rename_pkg::lane_cnt_t      alloc_num,
    output logic                       alloc_take,

    // Renamed group towards dispatch.
    output logic                       out_valid   [rename_pkg::RENAME_WIDTH],
    output logic                       out_we      [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t          out_prs1    [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t          out_prs2    [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t          out_prd     [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t          out_old_prd [rename_pkg::RENAME_WIDTH]
);

    import rename_pkg::*;

    logic      wr_lane   [RENAME_WIDTH];
    logic      waw_later [RENAME_WIDTH];
    lane_idx_t prd_idx   [RENAME_WIDTH];
    preg_t     prd       [RENAME_WIDTH];
    preg_t     prs1      [RENAME_WIDTH];
    preg_t     prs2      [RENAME_WIDTH];
    preg_t     old_prd   [RENAME_WIDTH];
    lane_cnt_t wr_count;
    logic      any_valid;
    logic      accept;

    // ****************************************
    // Allocation
    // ****************************************

    // A writing lane takes the free entry numbered by the writers below it.
    always_comb begin
        wr_count  = '0;
        any_valid = 1'b0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            wr_lane[i] = in_valid[i] & in_we[i];
            prd_idx[i] = lane_idx_t'(wr_count);
            prd[i]     = wr_lane[i] ? alloc_preg[prd_idx[i]] : '0;
            any_valid  = any_valid | in_valid[i];
            if (wr_lane[i]) begin
                wr_count = wr_count + 1'b1;
            end
        end
    end

    assign alloc_num = wr_count;

    // ****************************************
    // Dependencies inside the group
    // ****************************************

    // Scanning older lanes upwards lets the nearest earlier writer win.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            prs1[i]      = map_rs1[i];
            prs2[i]      = map_rs2[i];
            old_prd[i]   = map_rd[i];
            waw_later[i] = 1'b0;
            for (int j = 0; j < RENAME_WIDTH; j++) begin
                if (j < i && wr_lane[j]) begin
                    if (in_rs1[i] == in_rd[j]) begin
                        prs1[i] = prd[j];
                    end
                    if (in_rs2[i] == in_rd[j]) begin
                        prs2[i] = prd[j];
                    end
                    if (in_rd[i] == in_rd[j]) begin
                        old_prd[i] = prd[j];
                    end
                end
                // A younger writer of the same register owns the table entry.
                if (j > i && wr_lane[j] && in_rd[j] == in_rd[i]) begin
                    waw_later[i] = 1'b1;
                end
            end
        end
    end

    assign accept     = any_valid & ~stall & ~full;
    assign alloc_take = accept;

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rd_rs1[i]  = in_rs1[i];
            rd_rs2[i]  = in_rs2[i];
            rd_rd[i]   = in_rd[i];
            wr_en[i]   = accept & wr_lane[i] & ~waw_later[i];
            wr_areg[i] = in_rd[i];
            wr_preg[i] = prd[i];
        end
    end

    // ****************************************
    // Output register
    // ****************************************

    // Stall freezes the stage. Otherwise a rejected or empty group leaves a bubble.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                out_valid[i] <= 1'b0;
                out_we[i]    <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                out_valid[i] <= accept & in_valid[i];
                out_we[i]    <= accept & wr_lane[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_prs1    <= prs1;
            out_prs2    <= prs2;
            out_prd     <= prd;
            out_old_prd <= old_prd;
        end
    end

endmodule

`default_nettype wire

/* source/rename_top.sv */
`default_nettype none

module rename_top (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              in_valid [rename_pkg::RENAME_WIDTH],
    input  wire logic              in_we    [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t in_rs1   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t in_rs2   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::areg_t in_rd    [rename_pkg::RENAME_WIDTH],
    input  wire logic              stall,
    output logic                   full,

    input  wire logic              commit_valid   [rename_pkg::RENAME_WIDTH],
    input  wire rename_pkg::preg_t commit_old_prd [rename_pkg::RENAME_WIDTH],

    output logic                   out_valid   [rename_pkg::RENAME_WIDTH],
    output logic                   out_we      [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      out_prs1    [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      out_prs2    [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      out_prd     [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_t      out_old_prd [rename_pkg::RENAME_WIDTH]
);

    import rename_pkg::*;

    // Table lookups and updates.
    areg_t     rd_rs1  [RENAME_WIDTH];
    areg_t     rd_rs2  [RENAME_WIDTH];
    areg_t     rd_rd   [RENAME_WIDTH];
    preg_t     map_rs1 [RENAME_WIDTH];
    preg_t     map_rs2 [RENAME_WIDTH];
    preg_t     map_rd  [RENAME_WIDTH];
    logic      wr_en   [RENAME_WIDTH];
    areg_t     wr_areg [RENAME_WIDTH];
    preg_t     wr_preg [RENAME_WIDTH];

    // Free list handshake.
    preg_t     alloc_preg [RENAME_WIDTH];
    lane_cnt_t alloc_num;
    logic      alloc_take;

    rename_table u_table (
        .clk     (clk),
        .rst     (rst),
        .rd_rs1  (rd_rs1),
        .rd_rs2  (rd_rs2),
        .rd_rd   (rd_rd),
        .map_rs1 (map_rs1),
        .map_rs2 (map_rs2),
        .map_rd  (map_rd),
        .wr_en   (wr_en),
        .wr_areg (wr_areg),
        .wr_preg (wr_preg)
    );

    free_list u_free_list (
        .clk            (clk),
        .rst            (rst),
        .alloc_num      (alloc_num),
        .alloc_take     (alloc_take),
        .alloc_preg     (alloc_preg),
        .full           (full),
        .commit_valid   (commit_valid),
        .commit_old_prd (commit_old_prd)
    );

    rename_stage u_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_we       (in_we),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_rd       (in_rd),
        .stall       (stall),
        .full        (full),
        .rd_rs1      (rd_rs1),
        .rd_rs2      (rd_rs2),
        .rd_rd       (rd_rd),
        .map_rs1     (map_rs1),
        .map_rs2     (map_rs2),
        .map_rd      (map_rd),
        .wr_en       (wr_en),
        .wr_areg     (wr_areg),
        .wr_preg     (wr_preg),
        .alloc_preg  (alloc_preg),
        .alloc_num   (alloc_num),
        .alloc_take  (alloc_take),
        .out_valid   (out_valid),
        .out_we      (out_we),
        .out_prs1    (out_prs1),
        .out_prs2    (out_prs2),
        .out_prd     (out_prd),
        .out_old_prd (out_old_prd)
    );

endmodule

`default_nettype wire

/* verification/rename_tb.sv */
`default_nettype none

module rename_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;

    logic  clk;
    logic  rst;
    logic  in_valid [RENAME_WIDTH];
    logic  in_we    [RENAME_WIDTH];
    areg_t in_rs1   [RENAME_WIDTH];
    areg_t in_rs2   [RENAME_WIDTH];
    areg_t in_rd    [RENAME_WIDTH];
    logic  stall;
    logic  full;
    logic  commit_valid   [RENAME_WIDTH];
    preg_t commit_old_prd [RENAME_WIDTH];
    logic  out_valid   [RENAME_WIDTH];
    logic  out_we      [RENAME_WIDTH];
    preg_t out_prs1    [RENAME_WIDTH];
    preg_t out_prs2    [RENAME_WIDTH];
    preg_t out_prd     [RENAME_WIDTH];
    preg_t out_old_prd [RENAME_WIDTH];

    // Reference model of the map, the free queue and the registers awaiting release.
    logic [31:0] lfsr;
    preg_t       mtab [ARCH_REGS];
    preg_t       fq [$];
    preg_t       retire_q [$];

    // Group under test and its predicted renaming.
    logic  g_valid [RENAME_WIDTH];
    logic  g_we    [RENAME_WIDTH];
    areg_t g_rs1   [RENAME_WIDTH];
    areg_t g_rs2   [RENAME_WIDTH];
    areg_t g_rd    [RENAME_WIDTH];
    preg_t e_prs1    [RENAME_WIDTH];
    preg_t e_prs2    [RENAME_WIDTH];
    preg_t e_prd     [RENAME_WIDTH];
    preg_t e_old_prd [RENAME_WIDTH];

    rename_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ****************************************
    // Helpers
    // ****************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    function automatic int count_writers();
        int w;
        w = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (g_valid[i] && g_we[i]) begin
                w++;
            end
        end
        return w;
    endfunction

    task automatic make_group(input logic [3:0] valid, input logic [3:0] we);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            g_valid[i] = valid[i];
            g_we[i]    = we[i];
            g_rs1[i]   = areg_t'(rand_bits(5));
            g_rs2[i]   = areg_t'(rand_bits(5));
            g_rd[i]    = areg_t'(rand_bits(5));
        end
    endtask

    task automatic drive_group();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            in_valid[i] <= g_valid[i];
            in_we[i]    <= g_we[i];
            in_rs1[i]   <= g_rs1[i];
            in_rs2[i]   <= g_rs2[i];
            in_rd[i]    <= g_rd[i];
        end
    endtask

    // The nearest earlier writer in the group wins over the map.
    // Writers take the free queue in order.
    task automatic predict_group();
        int w;
        w = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            e_prs1[i]    = mtab[g_rs1[i]];
            e_prs2[i]    = mtab[g_rs2[i]];
            e_old_prd[i] = mtab[g_rd[i]];
            e_prd[i]     = '0;
            for (int j = 0; j < i; j++) begin
                if (g_valid[j] && g_we[j]) begin
                    if (g_rs1[i] == g_rd[j]) e_prs1[i] = e_prd[j];
                    if (g_rs2[i] == g_rd[j]) e_prs2[i] = e_prd[j];
                    if (g_rd[i] == g_rd[j]) e_old_prd[i] = e_prd[j];
                end
            end
            if (g_valid[i] && g_we[i]) begin
                e_prd[i] = fq[w];
                w++;
            end
        end
    endtask

    task automatic update_model();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (g_valid[i] && g_we[i]) begin
                mtab[g_rd[i]] = e_prd[i];
                void'(fq.pop_front());
                retire_q.push_back(e_old_prd[i]);
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            compare(32'(out_valid[i]), 32'(g_valid[i]), $sformatf("out_valid[%0d]", i));
            compare(32'(out_we[i]), 32'(g_valid[i] & g_we[i]), $sformatf("out_we[%0d]", i));
            if (g_valid[i]) begin
                compare(32'(out_prs1[i]), 32'(e_prs1[i]), $sformatf("out_prs1[%0d]", i));
                compare(32'(out_prs2[i]), 32'(e_prs2[i]), $sformatf("out_prs2[%0d]", i));
            end
            if (g_valid[i] && g_we[i]) begin
                compare(32'(out_prd[i]), 32'(e_prd[i]), $sformatf("out_prd[%0d]", i));
                compare(32'(out_old_prd[i]), 32'(e_old_prd[i]), $sformatf("out_old_prd[%0d]", i));
            end
        end
    endtask

    // Entered just after a rising edge. Holds the group until full drops, then
    // checks the renamed group and keeps checking it through nstall stalled cycles.
    task automatic send_group(input int nstall);
        int waits;
        drive_group();
        @(negedge clk);
        compare(32'(full), 32'(fq.size() < count_writers()), "full");
        waits = 0;
        while (full) begin
            if (waits == 16) begin
                abort_run("Timeout: full stayed high and the group was never accepted");
            end else begin
                waits++;
                @(negedge clk);
            end
        end
        predict_group();
        @(posedge clk);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            in_valid[i] <= 1'b0;
        end
        stall <= (nstall > 0);
        update_model();
        @(negedge clk);
        check_outputs();
        for (int k = 0; k < nstall; k++) begin
            @(posedge clk);
            if (k == nstall - 1) stall <= 1'b0;
            @(negedge clk);
            check_outputs();
        end
        @(posedge clk);
    endtask

    task automatic commit_regs(input logic [3:0] mask);
        preg_t p;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (mask[i] && retire_q.size() > 0) begin
                p = retire_q.pop_front();
                commit_valid[i]   <= 1'b1;
                commit_old_prd[i] <= p;
                fq.push_back(p);
            end else begin
                commit_valid[i] <= 1'b0;
            end
        end
        @(posedge clk);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            commit_valid[i] <= 1'b0;
        end
    endtask

    // ****************************************
    // Directed tests
    // ****************************************

    task automatic reset_allocation();
        int base;
        @(negedge clk);
        compare(32'(full), 32'd0, "full after reset");
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            compare(32'(out_valid[i]), 32'd0, "out_valid after reset");
        end
        @(posedge clk);
        make_group(4'hF, 4'hF);
        base = int'(rand_bits(5) % 28);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            g_rd[i] = areg_t'(base + i);
        end
        send_group(0);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            compare(32'(out_prd[i]), 32'(ARCH_REGS + i), "first allocation");
            compare(32'(out_old_prd[i]), 32'(g_rd[i]), "old register after reset");
        end
    endtask

    task automatic forward_in_group();
        make_group(4'hF, 4'b0011);
        g_rd[1]  = g_rd[0] + 1'b1;
        g_rs1[2] = g_rd[0];
        g_rs1[3] = g_rd[0];
        g_rs2[3] = g_rd[1];
        send_group(0);
    endtask

    task automatic same_dest_pair();
        areg_t r;
        make_group(4'hF, 4'hF);
        g_rd[1] = g_rd[3];
        g_rd[2] = g_rd[3] ^ 5'd1;
        g_rd[0] = g_rd[3] ^ 5'd2;
        r = g_rd[3];
        send_group(0);
        make_group(4'b0001, 4'b0000);
        g_rs1[0] = r;
        g_rs2[0] = r;
        send_group(0);
    endtask

    task automatic stall_hold();
        make_group(4'hF, 4'(rand_bits(4)));
        send_group(5);
        make_group(4'hF, 4'(rand_bits(4)));
        send_group(0);
    endtask

    // Drains the free list to empty, blocks a group, then releases in two steps.
    task automatic full_and_release();
        while (fq.size() >= RENAME_WIDTH) begin
            make_group(4'hF, 4'hF);
            send_group(0);
        end
        if (fq.size() > 0) begin
            make_group(4'hF, 4'((1 << fq.size()) - 1));
            send_group(0);
        end
        make_group(4'hF, 4'hF);
        drive_group();
        @(negedge clk);
        compare(32'(full), 32'd1, "full with an empty free list");
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            compare(32'(out_valid[i]), 32'd0, "out_valid while full");
        end
        @(posedge clk);
        commit_regs(4'b1101);
        @(negedge clk);
        compare(32'(full), 32'd1, "full after a partial release");
        @(posedge clk);
        commit_regs(4'b0110);
        send_group(0);
    endtask

    task automatic random_run();
        logic [3:0] valid;
        int         nstall;
        for (int n = 0; n < 200; n++) begin
            valid = 4'(rand_bits(4));
            if (valid == 4'h0) valid = 4'h1;
            make_group(valid, 4'(rand_bits(4)));
            if (rand_bits(1) == 1) commit_regs(4'(rand_bits(4)));
            while (fq.size() < count_writers()) begin
                commit_regs(4'hF);
            end
            nstall = (rand_bits(2) == 0) ? int'(rand_bits(2)) + 1 : 0;
            send_group(nstall);
        end
    endtask

    initial begin
        lfsr  = 32'h2237;
        rst   <= 1'b1;
        stall <= 1'b0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            in_valid[i]       <= 1'b0;
            in_we[i]          <= 1'b0;
            in_rs1[i]         <= '0;
            in_rs2[i]         <= '0;
            in_rd[i]          <= '0;
            commit_valid[i]   <= 1'b0;
            commit_old_prd[i] <= '0;
        end
        for (int a = 0; a < ARCH_REGS; a++) begin
            mtab[a] = preg_t'(a);
        end
        for (int e = 0; e < FREE_REGS; e++) begin
            fq.push_back(preg_t'(ARCH_REGS + e));
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_allocation();
        forward_in_group();
        same_dest_pair();
        stall_hold();
        full_and_release();
        random_run();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
source/rename_pkg.sv
source/rename_table.sv
source/free_list.sv
source/rename_stage.sv
source/rename_top.sv
verification/rename_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := rename_tb
FILELIST := src.f
OBJDIR   := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
